// File: alu_execute.sv
`default_nettype none

module alu_execute (
	input wire iCLOCK,
	input wire inRESET,
	input wire exec_types_pkg::exec_op_t op,
	input wire op_valid,
	output logic op_ready,
	input wire issue_hold,
	output exec_types_pkg::exec_result_t res,
	output logic res_valid,
	input wire res_ready,
	output logic busy,
	output exec_types_pkg::exec_flags_t flagr
);
	import exec_types_pkg::*;

	// Stage 1 holds the operands
	logic s1_valid;
	exec_op_t s1_op;

	// Stage 2 holds the raw result
	logic s2_valid;
	logic [EXEC_TAG_W-1:0] s2_tag;
	logic [EXEC_DATA_W-1:0] s2_value;
	logic s2_carry;
	logic s2_overflow;

	logic advance;
	logic op_take;
	logic [EXEC_SHAMT_W-1:0] s1_shamt;
	logic [EXEC_DATA_W-1:0] s1_value;
	logic s1_carry;
	logic s1_overflow;

	// Both stages move together, or not at all
	assign advance = !s2_valid || res_ready;
	assign op_ready = !issue_hold && advance;
	assign op_take = op_valid && op_ready;
	assign busy = s1_valid || s2_valid;
	assign res_valid = s2_valid;

	always_comb begin
		s1_shamt = s1_op.operand_b[EXEC_SHAMT_W-1:0];
		s1_value = '0;
		s1_carry = 1'b0;
		s1_overflow = 1'b0;
		case (s1_op.opcode)
			ADD: begin
				{s1_carry, s1_value} = {1'b0, s1_op.operand_a} + {1'b0, s1_op.operand_b};
				s1_overflow = (s1_op.operand_a[EXEC_DATA_W-1] == s1_op.operand_b[EXEC_DATA_W-1])
					&& (s1_value[EXEC_DATA_W-1] != s1_op.operand_a[EXEC_DATA_W-1]);
			end
			SUB: begin
				{s1_carry, s1_value} = {1'b0, s1_op.operand_a} - {1'b0, s1_op.operand_b};
				s1_overflow = (s1_op.operand_a[EXEC_DATA_W-1] != s1_op.operand_b[EXEC_DATA_W-1])
					&& (s1_value[EXEC_DATA_W-1] != s1_op.operand_a[EXEC_DATA_W-1]);
			end
			AND: s1_value = s1_op.operand_a & s1_op.operand_b;
			OR: s1_value = s1_op.operand_a | s1_op.operand_b;
			XOR: s1_value = s1_op.operand_a ^ s1_op.operand_b;
			// Extra bit catches the last bit shifted out
			SHL: {s1_carry, s1_value} = {1'b0, s1_op.operand_a} << s1_shamt;
			SHR: {s1_value, s1_carry} = {s1_op.operand_a, 1'b0} >> s1_shamt;
			PASS_B: s1_value = s1_op.operand_b;
			default: s1_value = '0;
		endcase
	end

	always_comb begin
		res.tag = s2_tag;
		res.value = s2_value;
		res.flags.zero = (s2_value == '0);
		res.flags.sign = s2_value[EXEC_DATA_W-1];
		res.flags.carry = s2_carry;
		res.flags.overflow = s2_overflow;
		res.flags.parity = ^s2_value;
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			flagr <= '0;
		end else begin
			if (advance) begin
				s1_valid <= op_take;
				s2_valid <= s1_valid;
			end
			// Flags of the op that retires this cycle
			if (s2_valid && res_ready) begin
				flagr <= res.flags;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (advance) begin
			if (op_take) begin
				s1_op <= op;
			end
			s2_tag <= s1_op.tag;
			s2_value <= s1_value;
			s2_carry <= s1_carry;
			s2_overflow <= s1_overflow;
		end
	end

endmodule

`default_nettype wire

// File: axi_lite_debug_port.sv
`default_nettype none

module axi_lite_debug_port (
	input wire iCLOCK,
	input wire inRESET,
	input wire debug_regs_pkg::axi_lite_req_t axi_req,
	output debug_regs_pkg::axi_lite_rsp_t axi_rsp,
	output debug_regs_pkg::dbg_cmd_t dbg_cmd,
	output logic dbg_cmd_valid,
	input wire dbg_ack,
	input wire halted,
	input wire busy,
	input wire exec_types_pkg::exec_flags_t flagr
);
	import debug_regs_pkg::*;

	logic wr_ready_q;
	logic bvalid_q;
	logic [1:0] bresp_q;
	logic rd_ready_q;
	logic rvalid_q;
	logic [1:0] rresp_q;
	logic [DBG_DATA_W-1:0] rdata_q;
	logic pending;

	logic wr_fire;
	logic rd_fire;
	logic wr_ctrl;
	logic cmd_bits_set;
	logic cmd_issue;
	logic [DBG_DATA_W-1:0] rd_word;
	logic [1:0] rd_resp;

	assign wr_fire = wr_ready_q && axi_req.awvalid && axi_req.wvalid;
	assign rd_fire = rd_ready_q && axi_req.arvalid;
	assign wr_ctrl = (axi_req.awaddr == DBG_ADDR_CTRL);
	assign cmd_bits_set = axi_req.wstrb[0] &&
		(axi_req.wdata[DBG_CTRL_STOP_BIT] || axi_req.wdata[DBG_CTRL_START_BIT]);
	// Writes that arrive while a command is pending are dropped
	assign cmd_issue = wr_fire && wr_ctrl && cmd_bits_set && !pending;

	always_comb begin
		rd_word = '0;
		rd_resp = AXI_RESP_OKAY;
		case (axi_req.araddr)
			DBG_ADDR_CTRL: rd_word = '0;
			DBG_ADDR_STATUS: begin
				rd_word[DBG_STATUS_HALTED_BIT] = halted;
				rd_word[DBG_STATUS_PENDING_BIT] = pending;
				rd_word[DBG_STATUS_BUSY_BIT] = busy;
			end
			DBG_ADDR_FLAGR: rd_word = DBG_DATA_W'(flagr);
			default: rd_resp = AXI_RESP_SLVERR;
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ready_q <= 1'b0;
			bvalid_q <= 1'b0;
			rd_ready_q <= 1'b0;
			rvalid_q <= 1'b0;
			pending <= 1'b0;
			dbg_cmd_valid <= 1'b0;
		end else begin
			wr_ready_q <= axi_req.awvalid && axi_req.wvalid && !wr_ready_q && !bvalid_q;
			rd_ready_q <= axi_req.arvalid && !rd_ready_q && !rvalid_q;
			if (wr_fire) begin
				bvalid_q <= 1'b1;
			end else if (axi_req.bready) begin
				bvalid_q <= 1'b0;
			end
			if (rd_fire) begin
				rvalid_q <= 1'b1;
			end else if (axi_req.rready) begin
				rvalid_q <= 1'b0;
			end
			if (cmd_issue) begin
				pending <= 1'b1;
			end else if (dbg_ack) begin
				pending <= 1'b0;
			end
			dbg_cmd_valid <= cmd_issue;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (wr_fire) begin
			bresp_q <= wr_ctrl ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
		end
		if (rd_fire) begin
			rdata_q <= rd_word;
			rresp_q <= rd_resp;
		end
		if (cmd_issue) begin
			dbg_cmd.stop <= axi_req.wdata[DBG_CTRL_STOP_BIT];
			dbg_cmd.start <= axi_req.wdata[DBG_CTRL_START_BIT];
		end
	end

	always_comb begin
		axi_rsp.awready = wr_ready_q;
		axi_rsp.wready = wr_ready_q;
		axi_rsp.bresp = bresp_q;
		axi_rsp.bvalid = bvalid_q;
		axi_rsp.arready = rd_ready_q;
		axi_rsp.rdata = rdata_q;
		axi_rsp.rresp = rresp_q;
		axi_rsp.rvalid = rvalid_q;
	end

	a_bvalid_hold: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		axi_rsp.bvalid && !axi_req.bready |=> axi_rsp.bvalid && $stable(axi_rsp.bresp));

	a_rvalid_hold: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		axi_rsp.rvalid && !axi_req.rready |=>
			axi_rsp.rvalid && $stable(axi_rsp.rdata) && $stable(axi_rsp.rresp));

endmodule

`default_nettype wire

// File: debug_regs_pkg.sv
`default_nettype none

package debug_regs_pkg;

	localparam int DBG_ADDR_W = 8;
	localparam int DBG_DATA_W = 32;

	// Register map
	localparam logic [DBG_ADDR_W-1:0] DBG_ADDR_CTRL = 8'h00;
	localparam logic [DBG_ADDR_W-1:0] DBG_ADDR_STATUS = 8'h04;
	localparam logic [DBG_ADDR_W-1:0] DBG_ADDR_FLAGR = 8'h08;

	// CTRL bits
	localparam int DBG_CTRL_STOP_BIT = 0;
	localparam int DBG_CTRL_START_BIT = 1;

	// STATUS bits
	localparam int DBG_STATUS_HALTED_BIT = 0;
	localparam int DBG_STATUS_PENDING_BIT = 1;
	localparam int DBG_STATUS_BUSY_BIT = 2;

	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
	localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic stop;
		logic start;
	} dbg_cmd_t;

	typedef struct packed {
		logic [DBG_ADDR_W-1:0] awaddr;
		logic awvalid;
		logic [DBG_DATA_W-1:0] wdata;
		logic [DBG_DATA_W/8-1:0] wstrb;
		logic wvalid;
		logic bready;
		logic [DBG_ADDR_W-1:0] araddr;
		logic arvalid;
		logic rready;
	} axi_lite_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
		logic arready;
		logic [DBG_DATA_W-1:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axi_lite_rsp_t;

endpackage

`default_nettype wire

// File: exec_debug_top.sv
`default_nettype none

module exec_debug_top (
	input wire iCLOCK,
	input wire inRESET,
	input wire exec_types_pkg::exec_op_t op_in,
	input wire op_valid,
	output wire op_ready,
	output exec_types_pkg::exec_result_t res_out,
	output wire res_valid,
	input wire res_ready,
	input wire debug_regs_pkg::axi_lite_req_t axi_req,
	output debug_regs_pkg::axi_lite_rsp_t axi_rsp
);
	import exec_types_pkg::*;
	import debug_regs_pkg::*;

	// Op queue to ALU
	exec_op_t q_op;
	logic q_op_valid;
	logic q_op_ready;

	// ALU to result queue
	exec_result_t alu_res;
	logic alu_res_valid;
	logic alu_res_ready;

	logic busy;
	exec_flags_t flagr;
	dbg_cmd_t dbg_cmd;
	logic dbg_cmd_valid;
	logic dbg_ack;
	logic issue_hold;
	logic halted;

	stream_fifo #(
		.payload_t(exec_op_t),
		.DEPTH(OP_FIFO_DEPTH)
	) op_fifo_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.in_data(op_in),
		.in_valid(op_valid),
		.in_ready(op_ready),
		.out_data(q_op),
		.out_valid(q_op_valid),
		.out_ready(q_op_ready)
	);

	axi_lite_debug_port axi_lite_debug_port_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.axi_req(axi_req),
		.axi_rsp(axi_rsp),
		.dbg_cmd(dbg_cmd),
		.dbg_cmd_valid(dbg_cmd_valid),
		.dbg_ack(dbg_ack),
		.halted(halted),
		.busy(busy),
		.flagr(flagr)
	);

	alu_execute alu_execute_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.op(q_op),
		.op_valid(q_op_valid),
		.op_ready(q_op_ready),
		.issue_hold(issue_hold),
		.res(alu_res),
		.res_valid(alu_res_valid),
		.res_ready(alu_res_ready),
		.busy(busy),
		.flagr(flagr)
	);

	execute_debugger execute_debugger_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.dbg_cmd(dbg_cmd),
		.dbg_cmd_valid(dbg_cmd_valid),
		.dbg_ack(dbg_ack),
		.issue_hold(issue_hold),
		.halted(halted),
		.busy(busy)
	);

	stream_fifo #(
		.payload_t(exec_result_t),
		.DEPTH(RES_FIFO_DEPTH)
	) res_fifo_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.in_data(alu_res),
		.in_valid(alu_res_valid),
		.in_ready(alu_res_ready),
		.out_data(res_out),
		.out_valid(res_valid),
		.out_ready(res_ready)
	);

endmodule

`default_nettype wire

// File: exec_types_pkg.sv
`default_nettype none

package exec_types_pkg;

	localparam int EXEC_DATA_W = 32;
	localparam int EXEC_TAG_W = 8;

	// Only the low bits of operand_b reach the shifter
	localparam int EXEC_SHAMT_W = 5;

	localparam int OP_FIFO_DEPTH = 4;
	localparam int RES_FIFO_DEPTH = 4;

	typedef enum logic [2:0] {
		ADD = 3'd0,
		SUB = 3'd1,
		AND = 3'd2,
		OR = 3'd3,
		XOR = 3'd4,
		SHL = 3'd5,
		SHR = 3'd6,
		PASS_B = 3'd7
	} exec_opcode_t;

	typedef struct packed {
		exec_opcode_t opcode;
		logic [EXEC_DATA_W-1:0] operand_a;
		logic [EXEC_DATA_W-1:0] operand_b;
		logic [EXEC_TAG_W-1:0] tag;
	} exec_op_t;

	// Carry on SUB is the borrow out of bit 31
	typedef struct packed {
		logic zero;
		logic sign;
		logic carry;
		logic overflow;
		logic parity;
	} exec_flags_t;

	typedef struct packed {
		logic [EXEC_TAG_W-1:0] tag;
		logic [EXEC_DATA_W-1:0] value;
		exec_flags_t flags;
	} exec_result_t;

endpackage

`default_nettype wire

// File: execute_debugger.sv
`default_nettype none

module execute_debugger (
	input wire iCLOCK,
	input wire inRESET,
	input wire debug_regs_pkg::dbg_cmd_t dbg_cmd,
	input wire dbg_cmd_valid,
	output logic dbg_ack,
	output logic issue_hold,
	output logic halted,
	input wire busy
);

	typedef enum logic [1:0] {
		IDLE,
		STOP_DRAIN,
		START_ACK
	} dbg_state_t;

	dbg_state_t state;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= IDLE;
			dbg_ack <= 1'b0;
			issue_hold <= 1'b0;
			halted <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					dbg_ack <= 1'b0;
					// Stop wins when both bits arrive together
					if (dbg_cmd_valid && dbg_cmd.stop) begin
						issue_hold <= 1'b1;
						state <= STOP_DRAIN;
					end else if (dbg_cmd_valid && dbg_cmd.start) begin
						issue_hold <= 1'b0;
						halted <= 1'b0;
						dbg_ack <= 1'b1;
						state <= START_ACK;
					end
				end
				STOP_DRAIN: begin
					// Wait for both ALU stages to empty
					if (!busy) begin
						halted <= 1'b1;
						dbg_ack <= 1'b1;
						state <= IDLE;
					end
				end
				START_ACK: begin
					dbg_ack <= 1'b0;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	a_ack_single: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		dbg_ack |=> !dbg_ack);

endmodule

`default_nettype wire

// File: files.f
+incdir+.
exec_types_pkg.sv
debug_regs_pkg.sv
stream_fifo.sv
axi_lite_debug_port.sv
execute_debugger.sv
alu_execute.sv
exec_debug_top.sv
tb_exec_debug.sv

// File: stream_fifo.sv
`default_nettype none

module stream_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input wire iCLOCK,
	input wire inRESET,
	input wire payload_t in_data,
	input wire in_valid,
	output logic in_ready,
	output payload_t out_data,
	output logic out_valid,
	input wire out_ready
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	// A full buffer still takes a word when one leaves in the same cycle
	assign in_ready = (count != CNT_W'(DEPTH)) || out_ready;
	assign out_valid = (count != '0);
	assign out_data = mem[rd_ptr];
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge iCLOCK) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_out_stable: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		out_valid && !out_ready |=> $stable(out_data));

endmodule

`default_nettype wire

// File: tb_exec_debug_model.svh
`ifndef TB_EXEC_DEBUG_MODEL_SVH
`define TB_EXEC_DEBUG_MODEL_SVH

// Expected tag, value and flags of one op
function automatic exec_result_t model_result(input exec_op_t op);
	exec_result_t r;
	logic [EXEC_DATA_W-1:0] a;
	logic [EXEC_DATA_W-1:0] b;
	logic [EXEC_DATA_W:0] ext;
	int sh;
	int ones;
	int i;
	a = op.operand_a;
	b = op.operand_b;
	sh = int'(b[EXEC_SHAMT_W-1:0]);
	r = '0;
	r.tag = op.tag;
	case (op.opcode)
		ADD: begin
			r.value = a + b;
			// Unsigned wrap means a carry out
			r.flags.carry = (r.value < a);
			ext = {a[EXEC_DATA_W-1], a} + {b[EXEC_DATA_W-1], b};
			r.flags.overflow = ext[EXEC_DATA_W] ^ ext[EXEC_DATA_W-1];
		end
		SUB: begin
			r.value = a - b;
			r.flags.carry = (a < b);
			ext = {a[EXEC_DATA_W-1], a} - {b[EXEC_DATA_W-1], b};
			r.flags.overflow = ext[EXEC_DATA_W] ^ ext[EXEC_DATA_W-1];
		end
		AND: r.value = a & b;
		OR: r.value = a | b;
		XOR: r.value = a ^ b;
		SHL: begin
			r.value = a << sh;
			if (sh != 0) begin
				r.flags.carry = a[EXEC_DATA_W - sh];
			end
		end
		SHR: begin
			r.value = a >> sh;
			if (sh != 0) begin
				r.flags.carry = a[sh - 1];
			end
		end
		PASS_B: r.value = b;
		default: r.value = '0;
	endcase
	ones = 0;
	for (i = 0; i < EXEC_DATA_W; i++) begin
		ones += r.value[i];
	end
	r.flags.zero = (ones == 0);
	r.flags.sign = r.value[EXEC_DATA_W-1];
	r.flags.parity = ones[0];
	return r;
endfunction

task automatic check_result(input exec_result_t got, input exec_result_t exp);
	if (got !== exp) begin
		result_errors++;
		$display("[ERROR] res_out: got tag=%h value=%h flags=%h, ",
			got.tag, got.value, got.flags,
			"expected tag=%h value=%h flags=%h", exp.tag, exp.value, exp.flags);
	end
endtask

task automatic check_word(input string name, input logic [DBG_DATA_W-1:0] got,
	input logic [DBG_DATA_W-1:0] exp);
	if (got !== exp) begin
		word_errors++;
		$display("[ERROR] %s: got %h expected %h", name, got, exp);
	end
endtask

task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
	if (got !== exp) begin
		resp_errors++;
		$display("[ERROR] %s: got %h expected %h", name, got, exp);
	end
endtask

`endif

// File: tb_exec_debug.sv
`default_nettype none

module tb_exec_debug;
	timeunit 1ns;
	timeprecision 1ps;
	import exec_types_pkg::*;
	import debug_regs_pkg::*;

	localparam int NUM_OPS = 300;
	localparam int MAX_POLLS = 100;
	localparam int WATCHDOG_CYCLES = NUM_OPS * 40 + 2000;
	localparam logic [31:0] SEED = 32'ha541532f;

	logic iCLOCK;
	logic inRESET;
	exec_op_t op_in;
	logic op_valid;
	logic op_ready;
	exec_result_t res_out;
	logic res_valid;
	logic res_ready;
	axi_lite_req_t axi_req;
	axi_lite_rsp_t axi_rsp;

	int result_errors = 0;
	int word_errors = 0;
	int resp_errors = 0;
	int other_errors = 0;
	int issued = 0;
	int received = 0;
	bit force_ready = 0;
	exec_flags_t last_flags = '0;
	exec_result_t exp_q[$];

	`include "tb_exec_debug_model.svh"

	exec_debug_top exec_debug_top_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.op_in(op_in),
		.op_valid(op_valid),
		.op_ready(op_ready),
		.res_out(res_out),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.axi_req(axi_req),
		.axi_rsp(axi_rsp)
	);

	initial begin
		iCLOCK = 1'b0;
		forever begin
			#10 iCLOCK = ~iCLOCK;
		end
	end

	function automatic exec_op_t random_op(input int idx);
		exec_op_t op;
		op.opcode = exec_opcode_t'($urandom_range(0, 7));
		op.operand_a = $urandom();
		op.operand_b = $urandom();
		// Equal operands now and then so SUB and XOR reach zero
		if ($urandom_range(0, 7) == 0) begin
			op.operand_b = op.operand_a;
		end
		op.tag = 8'(idx);
		return op;
	endfunction

	task automatic drive_stimulus();
		int loaded;
		loaded = -1;
		forever begin
			@(negedge iCLOCK);
			if (issued < NUM_OPS) begin
				if (loaded != issued) begin
					op_in = random_op(issued);
					loaded = issued;
					op_valid = 1'b0;
				end
				// Once raised, valid stays up until the op is taken
				if (!op_valid) begin
					op_valid = ($urandom_range(0, 3) != 0);
				end
			end else begin
				op_valid = 1'b0;
			end
			res_ready = force_ready || ($urandom_range(0, 2) != 0);
		end
	endtask

	task automatic monitor_streams();
		exec_result_t exp;
		forever begin
			@(posedge iCLOCK);
			if (inRESET && op_valid && op_ready) begin
				exp_q.push_back(model_result(op_in));
				issued++;
			end
			if (inRESET && res_valid && res_ready) begin
				if (exp_q.size() == 0) begin
					other_errors++;
					$display("Result with tag %h arrived with no op outstanding", res_out.tag);
				end else begin
					exp = exp_q.pop_front();
					check_result(res_out, exp);
					last_flags = exp.flags;
				end
				received++;
			end
		end
	endtask

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		@(negedge iCLOCK);
		axi_req.awaddr = addr;
		axi_req.awvalid = 1'b1;
		axi_req.wdata = data;
		axi_req.wstrb = 4'hf;
		axi_req.wvalid = 1'b1;
		axi_req.bready = 1'b1;
		do @(posedge iCLOCK); while (!axi_rsp.awready);
		if (!axi_rsp.wready) begin
			other_errors++;
			$display("wready was low in the cycle that awready rose");
		end
		@(negedge iCLOCK);
		axi_req.awvalid = 1'b0;
		axi_req.wvalid = 1'b0;
		do @(posedge iCLOCK); while (!axi_rsp.bvalid);
		resp = axi_rsp.bresp;
		@(negedge iCLOCK);
		axi_req.bready = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		@(negedge iCLOCK);
		axi_req.araddr = addr;
		axi_req.arvalid = 1'b1;
		axi_req.rready = 1'b1;
		do @(posedge iCLOCK); while (!axi_rsp.arready);
		@(negedge iCLOCK);
		axi_req.arvalid = 1'b0;
		do @(posedge iCLOCK); while (!axi_rsp.rvalid);
		data = axi_rsp.rdata;
		resp = axi_rsp.rresp;
		@(negedge iCLOCK);
		axi_req.rready = 1'b0;
	endtask

	// Poll STATUS until the command is done
	task automatic wait_status(input logic want_halted);
		logic [DBG_DATA_W-1:0] status;
		logic [1:0] resp;
		int polls;
		bit reached;
		polls = 0;
		reached = 1'b0;
		while (!reached && polls < MAX_POLLS) begin
			axi_read(DBG_ADDR_STATUS, status, resp);
			check_resp("rresp", resp, AXI_RESP_OKAY);
			reached = (status[DBG_STATUS_HALTED_BIT] == want_halted)
				&& !status[DBG_STATUS_PENDING_BIT]
				&& !(want_halted && status[DBG_STATUS_BUSY_BIT]);
			polls++;
		end
		if (!reached) begin
			other_errors++;
			$display("STATUS did not settle at halted=%0b after %0d reads", want_halted, polls);
		end
	endtask

	task automatic ctrl_write(input logic [31:0] data);
		logic [1:0] resp;
		axi_write(DBG_ADDR_CTRL, data, resp);
		check_resp("bresp", resp, AXI_RESP_OKAY);
	endtask

	task automatic print_counts();
		$display("Error counts: result=%0d word=%0d resp=%0d other=%0d",
			result_errors, word_errors, resp_errors, other_errors);
	endtask

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge iCLOCK);
		$display("Timeout after %0d cycles with %0d of %0d results received",
			WATCHDOG_CYCLES, received, NUM_OPS);
		print_counts();
		$display("Simulation failed");
		$finish;
	end

	initial begin : main
		logic [1:0] resp;
		logic [31:0] word;
		int drained_count;
		inRESET = 1'b0;
		op_in = '0;
		op_valid = 1'b0;
		res_ready = 1'b0;
		axi_req = '0;
		void'($urandom(SEED));
		repeat (5) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;
		fork
			drive_stimulus();
			monitor_streams();
		join_none

		// Stop while traffic is flowing
		wait (issued >= 100);
		ctrl_write(32'h1);
		wait_status(1'b1);
		force_ready = 1'b1;
		do @(posedge iCLOCK); while (res_valid);
		drained_count = received;
		repeat (20) @(posedge iCLOCK);
		if (received != drained_count) begin
			other_errors++;
			$display("Results kept arriving while halted, %0d then %0d", drained_count, received);
		end
		axi_read(DBG_ADDR_FLAGR, word, resp);
		check_resp("rresp", resp, AXI_RESP_OKAY);
		check_word("flagr", word, 32'(last_flags));

		// Bad accesses while halted
		axi_read(8'h0C, word, resp);
		check_resp("rresp", resp, AXI_RESP_SLVERR);
		check_word("rdata", word, 32'h0);
		axi_write(DBG_ADDR_STATUS, 32'h2, resp);
		check_resp("bresp", resp, AXI_RESP_SLVERR);
		axi_read(DBG_ADDR_STATUS, word, resp);
		check_resp("rresp", resp, AXI_RESP_OKAY);
		check_word("status.halted", 32'(word[DBG_STATUS_HALTED_BIT]), 32'h1);
		axi_read(DBG_ADDR_CTRL, word, resp);
		check_resp("rresp", resp, AXI_RESP_OKAY);
		force_ready = 1'b0;

		ctrl_write(32'h2);
		wait_status(1'b0);

		// Stop wins over a start in the same write
		wait (issued >= 200);
		ctrl_write(32'h3);
		wait_status(1'b1);
		ctrl_write(32'h2);
		wait_status(1'b0);

		wait (received >= NUM_OPS);
		repeat (10) @(posedge iCLOCK);
		if (exp_q.size() != 0 || received != NUM_OPS) begin
			other_errors++;
			$display("Received %0d results with %0d still expected", received, exp_q.size());
		end
		print_counts();
		if (result_errors + word_errors + resp_errors + other_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
